/* logic/board_io_pkg.sv */
// Board I/O shared definitions

`default_nettype none

package board_io_pkg;

    // Reset synchronizer depth in core clock cycles
    localparam int RST_SYNC_STAGES = 4;

    // Equal samples needed before a debounced output may change
    localparam int DEBOUNCE_DEPTH = 4;

    // 1 ms sample period at 125 MHz
    localparam int DEBOUNCE_RATE_DEFAULT = 125000;

    localparam int NUM_BUTTONS = 5;
    localparam int NUM_SWITCHES = 4;

    localparam int LED_WIDTH = 8;
    localparam int STATUS_WIDTH = 16;

    // PCS status speed field encodings
    localparam logic [1:0] SPEED_1000 = 2'b10;
    localparam logic [1:0] SPEED_100 = 2'b01;

    // PCS/PMA status vector
    // Raw word feeds the LED debug view, fields feed the speed decode
    typedef union packed {
        logic [STATUS_WIDTH-1:0] word;
        struct packed {
            logic [1:0] pause;
            logic       remote_fault;
            logic       duplex;
            logic [1:0] speed;
            logic [1:0] remote_fault_encdg;
            logic       phy_link_status;
            logic       rxnotintable;
            logic       rxdisperr;
            logic       rudi_invalid;
            logic       rudi_i;
            logic       rudi_c;
            logic       link_sync;
            // Bit 0
            logic       link_status;
        } fields;
    } pcs_status_t;

endpackage

`default_nettype wire

/* logic/reset_sync.sv */
// Core reset synchronizer

`timescale 1ns/1ps
`default_nettype none

module reset_sync
    import board_io_pkg::*;
(
    input  wire logic clk_125mhz,
    input  wire logic rst_n,
    input  wire logic mmcm_locked,
    output wire logic rst_core_n
);

// Either source going low asserts the core reset at once
wire logic rst_src_n = rst_n & mmcm_locked;

logic [RST_SYNC_STAGES-1:0] sync_reg;

// Ones shift in once both sources are high
always_ff @(posedge clk_125mhz or negedge rst_src_n) begin
    if (!rst_src_n) begin
        sync_reg <= '0;
    end else begin
        sync_reg <= {sync_reg[RST_SYNC_STAGES-2:0], 1'b1};
    end
end

// Release lands cleanly on the last stage in step with the clock
assign rst_core_n = sync_reg[RST_SYNC_STAGES-1];

endmodule

`default_nettype wire

/* logic/input_conditioner.sv */
// Button, switch and UART input conditioning

`timescale 1ns/1ps
`default_nettype none

module input_conditioner
    import board_io_pkg::*;
#(
    parameter int DEBOUNCE_RATE = DEBOUNCE_RATE_DEFAULT
)
(
    input  wire logic                    clk_125mhz,
    input  wire logic                    rst_n,

    // Buttons u, l, d, r, c from MSB
    input  wire logic [NUM_BUTTONS-1:0]  btn_raw,
    input  wire logic [NUM_SWITCHES-1:0] sw_raw,
    input  wire logic                    uart_rxd,
    input  wire logic                    uart_rts,

    output wire logic [NUM_BUTTONS-1:0]  btn,
    output wire logic [NUM_SWITCHES-1:0] sw,
    output wire logic                    uart_rxd_sync,
    output wire logic                    uart_rts_sync
);

localparam int NUM_INPUTS = NUM_BUTTONS + NUM_SWITCHES;
localparam int CNT_WIDTH = (DEBOUNCE_RATE > 1) ? $clog2(DEBOUNCE_RATE) : 1;

logic [CNT_WIDTH-1:0] sample_cnt;
logic                 sample_tick;

logic [DEBOUNCE_DEPTH-1:0] hist [NUM_INPUTS];
logic [NUM_INPUTS-1:0]     deb_reg;
wire logic [NUM_INPUTS-1:0] raw_in = {btn_raw, sw_raw};

logic [1:0] uart_s1;
logic [1:0] uart_s2;

// Shared sample period counter
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        sample_cnt <= '0;
        sample_tick <= 1'b0;
    end else begin
        sample_tick <= 1'b0;
        if (sample_cnt == CNT_WIDTH'(DEBOUNCE_RATE - 1)) begin
            sample_cnt <= '0;
            sample_tick <= 1'b1;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end
end

// Per-bit history and set/clear/hold output
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            hist[i] <= '0;
        end
        deb_reg <= '0;
    end else begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (sample_tick) begin
                hist[i] <= {hist[i][DEBOUNCE_DEPTH-2:0], raw_in[i]};
            end
            // Mixed history keeps the last settled value
            if (&hist[i]) begin
                deb_reg[i] <= 1'b1;
            end else if (~|hist[i]) begin
                deb_reg[i] <= 1'b0;
            end
        end
    end
end

assign btn = deb_reg[NUM_INPUTS-1:NUM_SWITCHES];
assign sw = deb_reg[NUM_SWITCHES-1:0];

// Two-stage synchronizer for the UART lines
always_ff @(posedge clk_125mhz) begin
    uart_s1 <= {uart_rxd, uart_rts};
    uart_s2 <= uart_s1;
end

assign uart_rxd_sync = uart_s2[1];
assign uart_rts_sync = uart_s2[0];

endmodule

`default_nettype wire

/* logic/status_led_select.sv */
// PCS status decode and LED debug select

`timescale 1ns/1ps
`default_nettype none

module status_led_select
    import board_io_pkg::*;
(
    // Raw switches straight from the board
    input  wire logic [NUM_SWITCHES-1:0] sw,
    input  wire logic [LED_WIDTH-1:0]    led_core,

    input  wire pcs_status_t             sgmii_status,
    input  wire pcs_status_t             sfp0_status,
    input  wire pcs_status_t             sfp1_status,

    output logic [LED_WIDTH-1:0]         led,
    output logic                         speed_is_10_100,
    output logic                         speed_is_100
);

pcs_status_t sel_status;

// sw[2] picks SFP over SGMII, sw[1] picks SFP1 over SFP0
always_comb begin
    if (sw[2]) begin
        sel_status = sw[1] ? sfp1_status : sfp0_status;
    end else begin
        sel_status = sgmii_status;
    end
end

// sw[3] shows a status byte, sw[0] selects the high byte
always_comb begin
    if (sw[3]) begin
        if (sw[0]) begin
            led = sel_status.word[STATUS_WIDTH-1 -: LED_WIDTH];
        end else begin
            led = sel_status.word[LED_WIDTH-1:0];
        end
    end else begin
        led = led_core;
    end
end

// SGMII rate adaption controls
always_comb begin
    speed_is_10_100 = sgmii_status.fields.speed != SPEED_1000;
    speed_is_100 = sgmii_status.fields.speed == SPEED_100;
end

endmodule

`default_nettype wire

/* logic/board_io.sv */
// Board-side I/O top level

`timescale 1ns/1ps
`default_nettype none

module board_io
    import board_io_pkg::*;
#(
    parameter int DEBOUNCE_RATE = DEBOUNCE_RATE_DEFAULT
)
(
    // 125 MHz core clock and active-low board reset
    input  wire logic                    clk_125mhz,
    input  wire logic                    rst_n,
    input  wire logic                    mmcm_locked,

    // GPIO
    input  wire logic                    btnu,
    input  wire logic                    btnl,
    input  wire logic                    btnd,
    input  wire logic                    btnr,
    input  wire logic                    btnc,
    input  wire logic [NUM_SWITCHES-1:0] sw_raw,

    // UART lines from the USB bridge
    input  wire logic                    uart_rxd,
    input  wire logic                    uart_rts,

    // Core LEDs and PCS status words
    input  wire logic [LED_WIDTH-1:0]    led_core,
    input  wire pcs_status_t             sgmii_status,
    input  wire pcs_status_t             sfp0_status,
    input  wire pcs_status_t             sfp1_status,

    // Core side
    output wire logic                    rst_core_n,
    output wire logic [NUM_BUTTONS-1:0]  btn,
    output wire logic [NUM_SWITCHES-1:0] sw,
    output wire logic                    uart_rxd_sync,
    output wire logic                    uart_rts_sync,

    // Board LEDs and SGMII speed controls
    output wire logic [LED_WIDTH-1:0]    led,
    output wire logic                    speed_is_10_100,
    output wire logic                    speed_is_100
);

reset_sync reset_sync_inst (
    .clk_125mhz  (clk_125mhz),
    .rst_n       (rst_n),
    .mmcm_locked (mmcm_locked),
    .rst_core_n  (rst_core_n)
);

// Conditioning runs in the core reset domain
input_conditioner #(
    .DEBOUNCE_RATE (DEBOUNCE_RATE)
)
input_conditioner_inst (
    .clk_125mhz    (clk_125mhz),
    .rst_n         (rst_core_n),
    .btn_raw       ({btnu, btnl, btnd, btnr, btnc}),
    .sw_raw        (sw_raw),
    .uart_rxd      (uart_rxd),
    .uart_rts      (uart_rts),
    .btn           (btn),
    .sw            (sw),
    .uart_rxd_sync (uart_rxd_sync),
    .uart_rts_sync (uart_rts_sync)
);

// Debug select reads the switches before debounce
status_led_select status_led_select_inst (
    .sw              (sw_raw),
    .led_core        (led_core),
    .sgmii_status    (sgmii_status),
    .sfp0_status     (sfp0_status),
    .sfp1_status     (sfp1_status),
    .led             (led),
    .speed_is_10_100 (speed_is_10_100),
    .speed_is_100    (speed_is_100)
);

endmodule

`default_nettype wire

/* verif/board_io_checker.sv */
// Reset and synchronizer assertions

`timescale 1ns/1ps
`default_nettype none

module board_io_checker
    import board_io_pkg::*;
(
    input wire logic clk_125mhz,
    input wire logic rst_n,
    input wire logic mmcm_locked,
    input wire logic rst_core_n,
    input wire logic uart_rxd,
    input wire logic uart_rts,
    input wire logic uart_rxd_sync,
    input wire logic uart_rts_sync
);

wire logic src_ok = rst_n & mmcm_locked;

// Lost lock holds the core in reset
lock_holds_reset: assert property (@(posedge clk_125mhz) !mmcm_locked |-> !rst_core_n)
    else $error("core reset high while clock manager unlocked");

// Release only after a full run of stable sources
release_after_stages: assert property (@(posedge clk_125mhz)
    $rose(rst_core_n) |-> $past(src_ok, 1) && $past(src_ok, 2) && $past(src_ok, 3)
        && $past(src_ok, RST_SYNC_STAGES))
    else $error("core reset released early");

rxd_two_stage: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
    uart_rxd_sync == $past(uart_rxd, 2))
    else $error("uart_rxd_sync does not match input from two cycles earlier");

rts_two_stage: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
    uart_rts_sync == $past(uart_rts, 2))
    else $error("uart_rts_sync does not match input from two cycles earlier");

endmodule

`default_nettype wire

/* verif/board_io_tb.sv */
// Board I/O testbench

`timescale 1ns/1ps
`default_nettype none

module board_io_tb
    import board_io_pkg::*;
();

localparam int SIM_RATE = 8;
localparam int RESET_CYCLES = 10;
localparam int ACCEPT_CYCLES = (DEBOUNCE_DEPTH + 1) * SIM_RATE + 2;
localparam int NUM_PATTERNS = 8;
localparam int REJECT_CYCLES = 6 * SIM_RATE;
localparam int UART_CYCLES = 100;
localparam int LED_CYCLES = 200;
// Twice the summed test lengths plus a fixed margin
localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 3 * RST_SYNC_STAGES
    + NUM_PATTERNS * (ACCEPT_CYCLES + 1) + REJECT_CYCLES + UART_CYCLES + LED_CYCLES) + 100;

logic                    clk_125mhz;
logic                    rst_n;
logic                    mmcm_locked;
logic                    btnu;
logic                    btnl;
logic                    btnd;
logic                    btnr;
logic                    btnc;
logic [NUM_SWITCHES-1:0] sw_raw;
logic                    uart_rxd;
logic                    uart_rts;
logic [LED_WIDTH-1:0]    led_core;
logic [STATUS_WIDTH-1:0] sgmii_status;
logic [STATUS_WIDTH-1:0] sfp0_status;
logic [STATUS_WIDTH-1:0] sfp1_status;

wire logic                    rst_core_n;
wire logic [NUM_BUTTONS-1:0]  btn;
wire logic [NUM_SWITCHES-1:0] sw;
wire logic                    uart_rxd_sync;
wire logic                    uart_rts_sync;
wire logic [LED_WIDTH-1:0]    led;
wire logic                    speed_is_10_100;
wire logic                    speed_is_100;

int          error_count;
logic [31:0] rand_state;
logic        led_check_en;
logic [8:0]  pattern;

board_io #(
    .DEBOUNCE_RATE (SIM_RATE)
)
DUT (
    .clk_125mhz      (clk_125mhz),
    .rst_n           (rst_n),
    .mmcm_locked     (mmcm_locked),
    .btnu            (btnu),
    .btnl            (btnl),
    .btnd            (btnd),
    .btnr            (btnr),
    .btnc            (btnc),
    .sw_raw          (sw_raw),
    .uart_rxd        (uart_rxd),
    .uart_rts        (uart_rts),
    .led_core        (led_core),
    .sgmii_status    (sgmii_status),
    .sfp0_status     (sfp0_status),
    .sfp1_status     (sfp1_status),
    .rst_core_n      (rst_core_n),
    .btn             (btn),
    .sw              (sw),
    .uart_rxd_sync   (uart_rxd_sync),
    .uart_rts_sync   (uart_rts_sync),
    .led             (led),
    .speed_is_10_100 (speed_is_10_100),
    .speed_is_100    (speed_is_100)
);

bind board_io board_io_checker checker_inst (
    .clk_125mhz    (clk_125mhz),
    .rst_n         (rst_n),
    .mmcm_locked   (mmcm_locked),
    .rst_core_n    (rst_core_n),
    .uart_rxd      (uart_rxd),
    .uart_rts      (uart_rts),
    .uart_rxd_sync (uart_rxd_sync),
    .uart_rts_sync (uart_rts_sync)
);

always #20 clk_125mhz = ~clk_125mhz;

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic next_random(output logic [31:0] value);
    rand_state = lcg_step(rand_state);
    value = rand_state;
endtask

// Expected LED bus from the raw switch rule
function automatic logic [LED_WIDTH-1:0] ref_led(input logic [3:0] sw_in,
        input logic [7:0] core, input logic [15:0] sgmii, input logic [15:0] sfp0,
        input logic [15:0] sfp1);
    logic [15:0] chosen;
    chosen = sw_in[2] ? (sw_in[1] ? sfp1 : sfp0) : sgmii;
    if (!sw_in[3]) begin
        return core;
    end
    return sw_in[0] ? chosen[15:8] : chosen[7:0];
endfunction

// Speed field sits at bits 11:10 of the status word
function automatic logic [1:0] ref_speed(input logic [15:0] sgmii);
    logic [1:0] speed;
    speed = sgmii[11:10];
    return {speed != 2'b10, speed == 2'b01};
endfunction

task automatic check_value(input string test_name, input logic [15:0] expected,
        input logic [15:0] actual);
    assert (actual === expected) else begin
        error_count++;
        $display("error %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic drive_pattern(input logic [8:0] pat);
    {btnu, btnl, btnd, btnr, btnc} = pat[8:4];
    sw_raw = pat[3:0];
endtask

// Core reset must rise on exactly the last synchronizer edge
task automatic check_reset_release(input string test_name);
    for (int k = 1; k <= RST_SYNC_STAGES; k++) begin
        @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        check_value(test_name, 16'(k == RST_SYNC_STAGES), 16'(rst_core_n));
    end
endtask

// Combinational outputs compared half a cycle after each drive
always @(posedge clk_125mhz) begin
    if (led_check_en) begin
        check_value("led_select",
            16'(ref_led(sw_raw, led_core, sgmii_status, sfp0_status, sfp1_status)), 16'(led));
        check_value("speed_decode", 16'(ref_speed(sgmii_status)),
            16'({speed_is_10_100, speed_is_100}));
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_125mhz);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
end

initial begin
    logic [31:0] rnd;
    logic        rxd_d1;
    logic        rxd_d2;
    logic        rts_d1;
    logic        rts_d2;
    clk_125mhz = 1'b0;
    rst_n = 1'b0;
    mmcm_locked = 1'b1;
    drive_pattern(9'd0);
    uart_rxd = 1'b1;
    uart_rts = 1'b0;
    led_core = '0;
    sgmii_status = '0;
    sfp0_status = '0;
    sfp1_status = '0;
    error_count = 0;
    rand_state = 32'd90;
    led_check_en = 1'b0;
    pattern = '0;

    repeat (RESET_CYCLES) @(negedge clk_125mhz);
    check_value("reset_hold", 16'd0, 16'(rst_core_n));
    rst_n = 1'b1;
    check_reset_release("reset_release");

    // Lost lock asserts the core reset without waiting for a clock
    mmcm_locked = 1'b0;
    #1;
    check_value("lock_drop", 16'd0, 16'(rst_core_n));
    @(negedge clk_125mhz);
    mmcm_locked = 1'b1;
    check_reset_release("lock_release");
    check_value("debounce_reset", 16'd0, 16'({btn, sw}));

    for (int p = 0; p < NUM_PATTERNS; p++) begin
        next_random(rnd);
        pattern = rnd[24:16];
        drive_pattern(pattern);
        repeat (ACCEPT_CYCLES) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        check_value("debounce_accept", 16'(pattern), 16'({btn, sw}));
    end

    // Three toggles per sample period keep consecutive samples different
    for (int c = 0; c < REJECT_CYCLES; c++) begin
        check_value("debounce_reject", 16'(pattern), 16'({btn, sw}));
        if ((c * 3) % SIM_RATE < 3) begin
            btnc = ~btnc;
        end
        @(negedge clk_125mhz);
    end
    btnc = pattern[4];
    check_value("debounce_reject", 16'(pattern), 16'({btn, sw}));

    rxd_d1 = uart_rxd;
    rxd_d2 = uart_rxd;
    rts_d1 = uart_rts;
    rts_d2 = uart_rts;
    for (int i = 0; i < UART_CYCLES; i++) begin
        @(negedge clk_125mhz);
        check_value("uart_rxd_sync", 16'(rxd_d2), 16'(uart_rxd_sync));
        check_value("uart_rts_sync", 16'(rts_d2), 16'(uart_rts_sync));
        rxd_d2 = rxd_d1;
        rts_d2 = rts_d1;
        next_random(rnd);
        uart_rxd = rnd[20];
        uart_rts = rnd[27];
        rxd_d1 = uart_rxd;
        rts_d1 = uart_rts;
    end

    for (int i = 0; i < LED_CYCLES; i++) begin
        next_random(rnd);
        sw_raw = rnd[19:16];
        led_core = rnd[31:24];
        next_random(rnd);
        sgmii_status = rnd[31:16];
        next_random(rnd);
        sfp0_status = rnd[31:16];
        next_random(rnd);
        sfp1_status = rnd[31:16];
        led_check_en = 1'b1;
        @(negedge clk_125mhz);
    end
    led_check_en = 1'b0;

    @(negedge clk_125mhz);
    $display("Checks complete with %0d errors", error_count);
    if (error_count == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

`default_nettype wire

/* board_io.f */
logic/board_io_pkg.sv
logic/reset_sync.sv
logic/input_conditioner.sv
logic/status_led_select.sv
logic/board_io.sv
verif/board_io_checker.sv
verif/board_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board_io simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f board_io.f \
    --top-module board_io_tb -Mdir obj_dir -o board_io_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/board_io_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
